/* flist.f */
+incdir+source
source/touch_cmd_pkg.sv
source/touch_coord_pkg.sv
source/touch_config_regs.sv
source/touch_spi_master.sv
source/touch_scan_sequencer.sv
source/touch_coord_scaler.sv
source/touch_subsystem.sv
tb/tb_clock_gen.sv
tb/touch_panel_model.sv
tb/touch_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the touch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f \
	--top-module touch_subsystem_tb -o touch_sim

# A fatal stop exits nonzero, the log search decides the result
./obj_dir/touch_sim > sim.log 2>&1 || true
cat sim.log

grep -q "^Testbench passed$" sim.log
echo "Simulation run finished without failure"

/* source/touch_cmd_pkg.sv */
package touch_cmd_pkg;

	// Command byte, sent LSB first
	// [0] start, [2:1] channel, [3] mode, [7:4] zero
	typedef logic [7:0] cmd_byte_t;

	// Channel select codes of the touch ADC
	typedef enum logic [1:0] {
		CH_X = 2'b10,
		CH_Y = 2'b00,
		CH_Z = 2'b01
	} channel_t;

	// Scan sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE,  // Waiting for enable and credit
		SEQ_START, // Issue one conversion
		SEQ_WAIT,  // Conversion in flight
		SEQ_EMIT   // Frame complete
	} seq_state_t;

	// Build the command for a channel with start and mode bits set
	function automatic cmd_byte_t make_cmd(channel_t ch);
		return {4'b0000, 1'b1, ch, 1'b1};
	endfunction

endpackage

/* source/touch_config_regs.sv */
`timescale 1ns/100ps
`include "touch_settings.svh"

module touch_config_regs (
	input  logic                       cclk,
	input  logic                       rstb,
	input  logic                       cfg_we,
	input  logic [2:0]                 cfg_addr,
	input  logic [15:0]                cfg_wdata,
	output logic [15:0]                cfg_rdata,
	output logic                       scan_en,
	output logic [`TOUCH_DIV_W-1:0]    clk_div,
	output touch_coord_pkg::rep_t      rep_count,
	output touch_coord_pkg::sample_t   x_min,
	output touch_coord_pkg::sample_t   y_min,
	output touch_coord_pkg::sample_t   z_thresh
);
	// Register map
	localparam logic [2:0] ADDR_EN     = 3'd0;
	localparam logic [2:0] ADDR_DIV    = 3'd1;
	localparam logic [2:0] ADDR_REP    = 3'd2;
	localparam logic [2:0] ADDR_XMIN   = 3'd3;
	localparam logic [2:0] ADDR_YMIN   = 3'd4;
	localparam logic [2:0] ADDR_ZTHR   = 3'd5;

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			scan_en   <= 1'b0; // Scanning off until software enables it
			clk_div   <= `TOUCH_DIV_RESET;
			rep_count <= `TOUCH_REP_RESET;
			x_min     <= `TOUCH_X_MIN_RESET;
			y_min     <= `TOUCH_Y_MIN_RESET;
			z_thresh  <= `TOUCH_Z_THRESH_RESET;
		end else if (cfg_we) begin
			case (cfg_addr) // Upper data bits dropped for narrow fields
				ADDR_EN:   scan_en   <= cfg_wdata[0];
				ADDR_DIV:  clk_div   <= cfg_wdata[`TOUCH_DIV_W-1:0];
				ADDR_REP:  rep_count <= cfg_wdata[`TOUCH_REP_W-1:0];
				ADDR_XMIN: x_min     <= cfg_wdata[`TOUCH_SAMPLE_W-1:0];
				ADDR_YMIN: y_min     <= cfg_wdata[`TOUCH_SAMPLE_W-1:0];
				ADDR_ZTHR: z_thresh  <= cfg_wdata[`TOUCH_SAMPLE_W-1:0];
				default: ; // Unmapped, write ignored
			endcase
		end
	end

	// Readback, zero extended
	always_comb begin
		case (cfg_addr)
			ADDR_EN:   cfg_rdata = 16'(scan_en);
			ADDR_DIV:  cfg_rdata = 16'(clk_div);
			ADDR_REP:  cfg_rdata = 16'(rep_count);
			ADDR_XMIN: cfg_rdata = 16'(x_min);
			ADDR_YMIN: cfg_rdata = 16'(y_min);
			ADDR_ZTHR: cfg_rdata = 16'(z_thresh);
			default:   cfg_rdata = '0;
		endcase
	end

endmodule

/* source/touch_coord_pkg.sv */
`include "touch_settings.svh"

package touch_coord_pkg;

	// Raw ADC value straight off the serial link
	typedef logic [`TOUCH_SAMPLE_W-1:0] sample_t;

	// Coordinate after calibration offset is removed
	typedef logic [`TOUCH_SAMPLE_W-1:0] coord_t;

	// Number of conversions per channel in one frame
	typedef logic [`TOUCH_REP_W-1:0] rep_t;

endpackage

/* source/touch_coord_scaler.sv */
`timescale 1ns/100ps

module touch_coord_scaler (
	input  logic                       cclk,
	input  logic                       rstb,
	input  logic                       raw_valid,
	input  touch_coord_pkg::sample_t   raw_x,
	input  touch_coord_pkg::sample_t   raw_y,
	input  touch_coord_pkg::sample_t   raw_z,
	input  touch_coord_pkg::sample_t   x_min,
	input  touch_coord_pkg::sample_t   y_min,
	input  touch_coord_pkg::sample_t   z_thresh,
	output logic                       frame_valid,
	output touch_coord_pkg::coord_t    pos_x,
	output touch_coord_pkg::coord_t    pos_y,
	output touch_coord_pkg::sample_t   pressure,
	output logic                       touched
);
	always_ff @(posedge cclk) begin
		if (!rstb)
			frame_valid <= 1'b0;
		else
			frame_valid <= raw_valid; // One stage behind the sequencer
	end

	// Frame payload, loaded with each new raw frame
	always_ff @(posedge cclk) begin
		if (raw_valid) begin
			// Offset removal, clamped at the panel edge
			pos_x    <= (raw_x > x_min) ? touch_coord_pkg::coord_t'(raw_x - x_min) : '0;
			pos_y    <= (raw_y > y_min) ? touch_coord_pkg::coord_t'(raw_y - y_min) : '0;
			pressure <= raw_z;
			touched  <= (raw_z >= z_thresh); // Threshold itself counts as a press
		end
	end

endmodule

/* source/touch_scan_sequencer.sv */
`timescale 1ns/100ps
`include "touch_settings.svh"

module touch_scan_sequencer (
	input  logic                       cclk,
	input  logic                       rstb,
	input  logic                       scan_en,
	input  touch_coord_pkg::rep_t      rep_count,
	input  logic                       credit_return,
	output logic                       start,
	output touch_cmd_pkg::channel_t    channel,
	input  logic                       xfer_busy,
	input  logic                       done,
	input  touch_coord_pkg::sample_t   sample,
	output logic                       raw_valid,
	output touch_coord_pkg::sample_t   raw_x,
	output touch_coord_pkg::sample_t   raw_y,
	output touch_coord_pkg::sample_t   raw_z
);
	localparam int CREDIT_W = $clog2(`TOUCH_CREDITS + 1);

	touch_cmd_pkg::seq_state_t  state;
	touch_coord_pkg::rep_t      rep_cnt;   // Conversions done on this channel
	logic [CREDIT_W-1:0]        credits;
	logic                       take;
	logic                       last_rep;

	assign take     = (state == touch_cmd_pkg::SEQ_EMIT); // Lines up with raw_valid
	assign last_rep = (rep_cnt + 1'b1 >= rep_count);       // Zero count acts as one

	// Consumer credit
	always_ff @(posedge cclk) begin
		if (!rstb)
			credits <= CREDIT_W'(`TOUCH_CREDITS);
		else
			credits <= credits - CREDIT_W'(take) + CREDIT_W'(credit_return);
	end

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state     <= touch_cmd_pkg::SEQ_IDLE;
			channel   <= touch_cmd_pkg::CH_X;
			rep_cnt   <= '0;
			start     <= 1'b0;
			raw_valid <= 1'b0;
		end else begin
			start     <= 1'b0;
			raw_valid <= 1'b0;
			case (state)
				touch_cmd_pkg::SEQ_IDLE: if (scan_en && credits != '0) begin
					channel <= touch_cmd_pkg::CH_X; // Every frame starts on X
					rep_cnt <= '0;
					state   <= touch_cmd_pkg::SEQ_START;
				end
				touch_cmd_pkg::SEQ_START: if (!xfer_busy) begin
					start <= 1'b1;
					state <= touch_cmd_pkg::SEQ_WAIT;
				end
				touch_cmd_pkg::SEQ_WAIT: if (done) begin
					if (!last_rep) begin
						rep_cnt <= rep_cnt + 1'b1; // Same channel again, panel settling
						state   <= touch_cmd_pkg::SEQ_START;
					end else begin
						rep_cnt <= '0;
						case (channel)
							touch_cmd_pkg::CH_X: begin
								channel <= touch_cmd_pkg::CH_Y;
								state   <= touch_cmd_pkg::SEQ_START;
							end
							touch_cmd_pkg::CH_Y: begin
								channel <= touch_cmd_pkg::CH_Z;
								state   <= touch_cmd_pkg::SEQ_START;
							end
							default: state <= touch_cmd_pkg::SEQ_EMIT; // Z was last
						endcase
					end
				end
				default: begin // SEQ_EMIT
					raw_valid <= 1'b1;
					state     <= touch_cmd_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	// Last conversion of each channel wins
	always_ff @(posedge cclk) begin
		if (state == touch_cmd_pkg::SEQ_WAIT && done) begin
			case (channel)
				touch_cmd_pkg::CH_X: raw_x <= sample;
				touch_cmd_pkg::CH_Y: raw_y <= sample;
				default:             raw_z <= sample;
			endcase
		end
	end

endmodule

/* source/touch_settings.svh */
`ifndef TOUCH_SETTINGS_SVH
`define TOUCH_SETTINGS_SVH

// Datapath widths
`define TOUCH_SAMPLE_W 12 // One ADC conversion result
`define TOUCH_DIV_W    16 // Serial clock half-period field
`define TOUCH_REP_W    8  // Conversions per channel

// Frames the consumer can buffer before it must return credit
`define TOUCH_CREDITS 2

// Register defaults after reset
`define TOUCH_DIV_RESET       100     // Slow enough for a cold panel
`define TOUCH_REP_RESET       15      // Settling repeats per channel
`define TOUCH_X_MIN_RESET     12'h090
`define TOUCH_Y_MIN_RESET     12'h060
`define TOUCH_Z_THRESH_RESET  12'h100 // Light press still counts as touch

`endif

/* source/touch_spi_master.sv */
`timescale 1ns/100ps
`include "touch_settings.svh"

module touch_spi_master (
	input  logic                       cclk,
	input  logic                       rstb,
	input  logic [`TOUCH_DIV_W-1:0]    clk_div,   // touch_clk half period in cclk cycles
	input  logic                       start,
	input  touch_cmd_pkg::channel_t    channel,
	output logic                       xfer_busy,
	output logic                       done,
	output touch_coord_pkg::sample_t   sample,
	output logic                       touch_csb,
	output logic                       touch_clk,
	output logic                       data_out,
	input  logic                       data_in
);
	// Transaction period map
	localparam logic [4:0] CMD_LAST    = 5'd7;  // Periods 0..7 carry the command
	localparam logic [4:0] RX_FIRST    = 5'd9;  // Period 8 is a gap
	localparam logic [4:0] RX_LAST     = 5'd20; // 12 data bits, MSB first
	localparam logic [4:0] LAST_PERIOD = 5'd24;

	logic [`TOUCH_DIV_W-1:0]    div_cnt;
	logic [4:0]                 period;    // Advances on each falling touch_clk
	touch_cmd_pkg::cmd_byte_t   cmd_word;
	touch_cmd_pkg::cmd_byte_t   cmd_sr;    // Remaining command bits
	touch_coord_pkg::sample_t   rx_sr;
	logic                       accept;
	logic                       tick;
	logic                       fall_tick;
	logic                       rise_tick;
	logic                       receiving;

	assign cmd_word  = touch_cmd_pkg::make_cmd(channel);
	assign accept    = start && !xfer_busy;
	assign tick      = xfer_busy && (div_cnt == clk_div - 1'b1);
	assign fall_tick = tick && touch_clk;  // Clock about to drop
	assign rise_tick = tick && !touch_clk;
	assign receiving = (period >= RX_FIRST) && (period <= RX_LAST);
	assign touch_csb = ~xfer_busy; // Chip select low for the whole transaction

	// Serial clock divider, parked low between transactions
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			div_cnt   <= '0;
			touch_clk <= 1'b0;
		end else if (!xfer_busy) begin
			div_cnt   <= '0;
			touch_clk <= 1'b0;
		end else if (tick) begin
			div_cnt   <= '0;
			touch_clk <= ~touch_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Period counter, command bit output and completion
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			xfer_busy <= 1'b0;
			done      <= 1'b0;
			data_out  <= 1'b0;
			period    <= '0;
		end else begin
			done <= 1'b0;
			if (accept) begin
				xfer_busy <= 1'b1;
				period    <= '0;
				data_out  <= cmd_word[0]; // Start bit leads period 0
			end else if (fall_tick) begin
				// Next command bit, or idle low from period 8 on
				data_out <= (period < CMD_LAST) ? cmd_sr[0] : 1'b0;
				if (period == LAST_PERIOD) begin
					xfer_busy <= 1'b0;
					done      <= 1'b1;
					period    <= '0;
				end else begin
					period <= period + 5'd1;
				end
			end
		end
	end

	// Shift registers and result
	always_ff @(posedge cclk) begin
		if (accept)
			cmd_sr <= cmd_word >> 1;
		else if (fall_tick)
			cmd_sr <= cmd_sr >> 1;
		if (rise_tick && receiving)
			rx_sr <= {rx_sr[`TOUCH_SAMPLE_W-2:0], data_in}; // MSB arrives first
		if (fall_tick && period == LAST_PERIOD)
			sample <= rx_sr;
	end

endmodule

/* source/touch_subsystem.sv */
`timescale 1ns/100ps
`include "touch_settings.svh"

module touch_subsystem (
	input  logic                       cclk,
	input  logic                       rstb,
	input  logic                       cfg_we,
	input  logic [2:0]                 cfg_addr,
	input  logic [15:0]                cfg_wdata,
	output logic [15:0]                cfg_rdata,
	output logic                       touch_csb,
	output logic                       touch_clk,
	output logic                       data_out,
	input  logic                       data_in,
	input  logic                       credit_return,
	output logic                       frame_valid,
	output touch_coord_pkg::coord_t    pos_x,
	output touch_coord_pkg::coord_t    pos_y,
	output touch_coord_pkg::sample_t   pressure,
	output logic                       touched
);
	// Configuration fan-out
	logic                       scan_en;
	logic [`TOUCH_DIV_W-1:0]    clk_div;
	touch_coord_pkg::rep_t      rep_count;
	touch_coord_pkg::sample_t   x_min;
	touch_coord_pkg::sample_t   y_min;
	touch_coord_pkg::sample_t   z_thresh;

	// Sequencer to master
	logic                       start;
	touch_cmd_pkg::channel_t    channel;
	logic                       xfer_busy;
	logic                       done;
	touch_coord_pkg::sample_t   sample;

	// Sequencer to scaler
	logic                       raw_valid;
	touch_coord_pkg::sample_t   raw_x;
	touch_coord_pkg::sample_t   raw_y;
	touch_coord_pkg::sample_t   raw_z;

	touch_config_regs u_regs (
		.cclk, .rstb, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
		.scan_en, .clk_div, .rep_count, .x_min, .y_min, .z_thresh
	);

	touch_spi_master u_master (
		.cclk, .rstb, .clk_div, .start, .channel, .xfer_busy, .done, .sample,
		.touch_csb, .touch_clk, .data_out, .data_in
	);

	touch_scan_sequencer u_seq (
		.cclk, .rstb, .scan_en, .rep_count, .credit_return, .start, .channel,
		.xfer_busy, .done, .sample, .raw_valid, .raw_x, .raw_y, .raw_z
	);

	touch_coord_scaler u_scaler (
		.cclk, .rstb, .raw_valid, .raw_x, .raw_y, .raw_z, .x_min, .y_min, .z_thresh,
		.frame_valid, .pos_x, .pos_y, .pressure, .touched
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic cclk,
	output logic rstb
);
	initial cclk = 1'b0;
	always #50 cclk = ~cclk; // 100 ns period

	initial begin
		rstb = 1'b0;
		repeat (16) @(posedge cclk);
		#10 rstb = 1'b1; // Released off the edge like other inputs
	end

endmodule

/* tb/touch_panel_model.sv */
`timescale 1ns/100ps

module touch_panel_model (
	input  logic        touch_csb,
	input  logic        touch_clk,
	input  logic        data_out,
	output logic        data_in,
	input  logic [11:0] x_val,
	input  logic [11:0] y_val,
	input  logic [11:0] z_val
);
	logic [7:0]  cmd_sr;
	logic [7:0]  cmd_log [0:1023]; // Every command byte seen, in order
	logic [11:0] value;            // Sample for the current conversion
	int          cmd_count;
	int          rise_cnt;
	int          fall_cnt;

	initial begin
		data_in   = 1'b0;
		cmd_count = 0;
		rise_cnt  = 0;
		fall_cnt  = 0;
		value     = '0;
	end

	// New transaction
	always @(negedge touch_csb) begin
		rise_cnt = 0;
		fall_cnt = 0;
	end

	// Command bits, LSB first, one per rising edge of periods 0..7
	always @(posedge touch_clk) begin
		if (!touch_csb && rise_cnt < 8) begin
			cmd_sr[rise_cnt] = data_out;
			rise_cnt = rise_cnt + 1;
			if (rise_cnt == 8) begin
				cmd_log[cmd_count % 1024] = cmd_sr;
				cmd_count = cmd_count + 1;
				case (cmd_sr[2:1]) // Channel field selects the table value
					2'b10:   value = x_val;
					2'b00:   value = y_val;
					default: value = z_val;
				endcase
			end
		end
	end

	// Falling edge n starts period n, data in periods 9..20 MSB first
	always @(negedge touch_clk) begin
		fall_cnt = fall_cnt + 1;
		if (fall_cnt >= 9 && fall_cnt <= 20)
			data_in <= value[20 - fall_cnt];
		else
			data_in <= 1'b0;
	end

endmodule

/* tb/touch_subsystem_tb.sv */
`timescale 1ns/100ps
`include "touch_settings.svh"

module touch_subsystem_tb;
	localparam int  NROWS        = 6;
	localparam int  DIV          = 2;
	localparam int  REP          = 2;
	localparam int  FRAME_CYCLES = 3 * REP * 50 * DIV + 50; // One frame plus slack
	// Table rows plus the disable, credit and quiet windows, doubled
	localparam longint TIMEOUT_NS = longint'(NROWS + 12) * 3 * REP * 50 * DIV * 100 * 2;

	logic        cclk, rstb;
	logic        cfg_we, data_in, credit_return;
	logic [2:0]  cfg_addr;
	logic [15:0] cfg_wdata, cfg_rdata;
	logic        touch_csb, touch_clk, data_out;
	logic        frame_valid, touched;
	logic [11:0] pos_x, pos_y, pressure;
	logic [11:0] x_val, y_val, z_val; // Panel values for the model

	// Test table
	logic [11:0] row_x [NROWS], row_y [NROWS], row_z [NROWS];
	logic [11:0] row_xmin [NROWS], row_ymin [NROWS], row_zthr [NROWS];
	logic [11:0] exp_x [NROWS], exp_y [NROWS];
	logic        exp_t [NROWS];
	int          seed;
	int          base;
	logic [31:0] r;

	tb_clock_gen clkgen (.cclk, .rstb);

	touch_subsystem dut (
		.cclk, .rstb, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
		.touch_csb, .touch_clk, .data_out, .data_in, .credit_return,
		.frame_valid, .pos_x, .pos_y, .pressure, .touched
	);

	touch_panel_model panel (
		.touch_csb, .touch_clk, .data_out, .data_in, .x_val, .y_val, .z_val
	);

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic report_error(string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic write_reg(logic [2:0] addr, logic [15:0] data);
		@(posedge cclk);
		#10 cfg_we = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		@(posedge cclk);
		#10 cfg_we = 1'b0;
	endtask

	task automatic read_reg(logic [2:0] addr, output logic [15:0] data);
		@(posedge cclk);
		#10 cfg_addr = addr;
		@(negedge cclk);
		data = cfg_rdata; // Combinational readback, settled mid-cycle
	endtask

	// Readback of one register against its expected value
	task automatic verify_reg(string name, logic [2:0] addr, logic [15:0] expected);
		logic [15:0] data;
		read_reg(addr, data);
		check_value(name, expected, data);
	endtask

	// One table row of panel values and calibration settings
	task automatic fill_row(int i, logic [11:0] x, logic [11:0] y, logic [11:0] z,
			logic [11:0] xmin, logic [11:0] ymin, logic [11:0] zthr);
		row_x[i]    = x;
		row_y[i]    = y;
		row_z[i]    = z;
		row_xmin[i] = xmin;
		row_ymin[i] = ymin;
		row_zthr[i] = zthr;
	endtask

	task automatic pulse_credit();
		@(posedge cclk);
		#10 credit_return = 1'b1;
		@(posedge cclk);
		#10 credit_return = 1'b0;
	endtask

	task automatic wait_frame();
		do @(negedge cclk); while (!frame_valid);
	endtask

	task automatic wait_scan_start();
		do @(negedge cclk); while (touch_csb);
	endtask

	// Frames seen in a window of cclk cycles
	task automatic count_frames(int cycles, output int n);
		n = 0;
		repeat (cycles) begin
			@(negedge cclk);
			if (frame_valid) n++;
		end
	endtask

	// Scaler rule, signed distance above the minimum, nothing below it
	function automatic logic [11:0] offset_pos(logic [11:0] raw, logic [11:0] min);
		int diff;
		diff = int'(raw) - int'(min);
		return (diff > 0) ? 12'(diff) : 12'h000;
	endfunction

	// Command byte expected for conversion i of a frame, X then Y then Z
	function automatic logic [7:0] expected_cmd(int i);
		case (i / REP)
			0:       return 8'h0D; // Channel 10, mode and start set
			1:       return 8'h09;
			default: return 8'h0B;
		endcase
	endfunction

	// Global timeout
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the tests completed");
		$display("Testbench failed");
		$fatal(1);
	end

	initial begin
		int n;
		cfg_we        = 1'b0;
		cfg_addr      = '0;
		cfg_wdata     = '0;
		credit_return = 1'b0;
		x_val         = '0;
		y_val         = '0;
		z_val         = '0;
		seed          = 32'hc9df06c1;

		// Fixed rows cover deep touch, below minimum and threshold edges
		fill_row(0, 12'h400, 12'h300, 12'h200, 12'h090, 12'h060, 12'h100);
		fill_row(1, 12'h050, 12'h020, 12'h0FF, 12'h090, 12'h060, 12'h100);
		fill_row(2, 12'h090, 12'h061, 12'h100, 12'h090, 12'h060, 12'h100);
		fill_row(3, 12'hFFF, 12'hFFF, 12'h0FF, 12'h800, 12'h7FF, 12'h100);
		for (int i = 4; i < NROWS; i++) begin
			r = $random(seed);
			row_x[i] = r[11:0];
			row_y[i] = r[27:16];
			r = $random(seed);
			row_z[i]    = r[11:0];
			row_zthr[i] = r[27:16];
			r = $random(seed);
			row_xmin[i] = r[11:0];
			row_ymin[i] = r[27:16];
		end
		for (int i = 0; i < NROWS; i++) begin
			exp_x[i] = offset_pos(row_x[i], row_xmin[i]);
			exp_y[i] = offset_pos(row_y[i], row_ymin[i]);
			exp_t[i] = (row_z[i] >= row_zthr[i]);
		end

		@(posedge rstb);
		@(negedge cclk);
		check_value("reset touch_csb", 1, touch_csb);
		check_value("reset touch_clk", 0, touch_clk);
		check_value("reset data_out", 0, data_out);
		check_value("reset frame_valid", 0, frame_valid);
		verify_reg("reset enable", 0, 0);
		verify_reg("reset clk_div", 1, `TOUCH_DIV_RESET);
		verify_reg("reset rep_count", 2, `TOUCH_REP_RESET);
		verify_reg("reset x_min", 3, `TOUCH_X_MIN_RESET);
		verify_reg("reset y_min", 4, `TOUCH_Y_MIN_RESET);
		verify_reg("reset z_thresh", 5, `TOUCH_Z_THRESH_RESET);

		// Readback with truncation, enable written with bit 0 clear
		write_reg(0, 16'hFFFE);
		verify_reg("cfg enable", 0, 16'h0000);
		write_reg(1, 16'hABCD);
		verify_reg("cfg clk_div", 1, 16'hABCD);
		write_reg(2, 16'h1234);
		verify_reg("cfg rep_count", 2, 16'h0034);
		write_reg(3, 16'hF123);
		verify_reg("cfg x_min", 3, 16'h0123);
		write_reg(4, 16'hE456);
		verify_reg("cfg y_min", 4, 16'h0456);
		write_reg(5, 16'hD789);
		verify_reg("cfg z_thresh", 5, 16'h0789);

		write_reg(1, DIV);
		write_reg(2, REP);

		for (int i = 0; i < NROWS; i++) begin
			x_val = row_x[i];
			y_val = row_y[i];
			z_val = row_z[i];
			write_reg(3, row_xmin[i]);
			write_reg(4, row_ymin[i]);
			write_reg(5, row_zthr[i]);
			base = panel.cmd_count;
			write_reg(0, 1);
			verify_reg($sformatf("row %0d enable", i), 0, 16'h0001);
			wait_scan_start();
			write_reg(0, 0); // One frame only, then stay idle
			wait_frame();
			check_value($sformatf("row %0d pos_x", i), exp_x[i], pos_x);
			check_value($sformatf("row %0d pos_y", i), exp_y[i], pos_y);
			check_value($sformatf("row %0d pressure", i), row_z[i], pressure);
			check_value($sformatf("row %0d touched", i), exp_t[i], touched);
			if (panel.cmd_count - base != 3 * REP)
				report_error($sformatf("Row %0d sent %0d commands instead of %0d",
					i, panel.cmd_count - base, 3 * REP));
			for (int k = 0; k < 3 * REP; k++)
				if (panel.cmd_log[(base + k) % 1024] !== expected_cmd(k))
					report_error($sformatf("Row %0d command %0d was %h, wrong channel or layout",
						i, k, panel.cmd_log[(base + k) % 1024]));
			pulse_credit();
		end

		// Disable mid frame, the bus must then stay quiet
		write_reg(0, 1);
		wait_scan_start();
		write_reg(0, 0);
		wait_frame();
		pulse_credit();
		repeat (2 * FRAME_CYCLES) begin
			@(negedge cclk);
			if (!touch_csb)
				report_error("A transaction began after scanning was disabled");
		end

		// Back-pressure, credits run out after the consumer depth
		write_reg(0, 1);
		repeat (`TOUCH_CREDITS) wait_frame();
		count_frames(2 * FRAME_CYCLES, n);
		check_value("frames without credit", 0, n);
		pulse_credit();
		wait_frame();
		count_frames(2 * FRAME_CYCLES, n);
		check_value("frames after one credit", 0, n);
		write_reg(0, 0);

		$display("Testbench passed");
		$finish;
	end

endmodule
